/* build.f */
+incdir+include
verilog/rf_pkg.sv
verilog/rf_nibble_ram.sv
verilog/rf_write_gather.sv
verilog/rf_read_scatter.sv
verilog/serial_regfile.sv
testbench/tb_serial_regfile.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --assert --top-module tb_serial_regfile -f build.f \
   -Mdir obj_dir -o tb_serial_regfile > build.log 2>&1 \
   && ./obj_dir/tb_serial_regfile > sim.log 2>&1 \
   || { echo "Build or simulation returned an error"; cat build.log sim.log 2>/dev/null; }
grep -q "^Simulation completed successfully$" sim.log 2>/dev/null \
   && { echo "PASS"; exit 0; } \
   || { echo "FAIL"; exit 1; }

/* include/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: op, rd or rs1, rs2, CSR slot, {csr_en, trap}, data,
// expected rs1, expected rs2, expected CSR word

localparam logic [1:0] OP_WRD  = 2'd0;
localparam logic [1:0] OP_WCSR = 2'd1;
localparam logic [1:0] OP_TRAP = 2'd2;
localparam logic [1:0] OP_READ = 2'd3;

typedef struct packed {
   logic [1:0]  op;
   logic [4:0]  ra1;
   logic [4:0]  ra2;
   logic [1:0]  csr;
   logic [1:0]  flags;
   logic [31:0] data;
   logic [31:0] exp_rs1;
   logic [31:0] exp_rs2;
   logic [31:0] exp_pc;
} vec_row_t;

localparam int N_VEC = 15;

localparam vec_row_t VEC_TBL [N_VEC] = '{
   '{OP_WCSR, 5'd0,  5'd0,  2'd0, 2'b00, 32'hcafe0001, 32'h0, 32'h0, 32'h0},
   '{OP_WCSR, 5'd0,  5'd0,  2'd1, 2'b00, 32'h80000100, 32'h0, 32'h0, 32'h0},
   '{OP_WRD,  5'd5,  5'd0,  2'd0, 2'b00, 32'ha5a50f0f, 32'h0, 32'h0, 32'h0},
   '{OP_WRD,  5'd17, 5'd0,  2'd0, 2'b00, 32'h13579bdf, 32'h0, 32'h0, 32'h0},
   '{OP_READ, 5'd5,  5'd17, 2'd0, 2'b00, 32'h00000000, 32'ha5a50f0f, 32'h13579bdf, 32'hcafe0001},
   '{OP_READ, 5'd17, 5'd5,  2'd0, 2'b10, 32'h0f0ff0f0, 32'h13579bdf, 32'ha5a50f0f, 32'hcafe0001},
   '{OP_READ, 5'd5,  5'd5,  2'd0, 2'b00, 32'h00000000, 32'ha5a50f0f, 32'ha5a50f0f, 32'h0f0ff0f0},
   '{OP_TRAP, 5'd0,  5'd0,  2'd0, 2'b00, 32'h00002468, 32'h0, 32'h0, 32'h0},
   '{OP_READ, 5'd17, 5'd17, 2'd2, 2'b00, 32'h00000000, 32'h13579bdf, 32'h13579bdf, 32'h00002468},
   '{OP_READ, 5'd5,  5'd17, 2'd3, 2'b00, 32'h00000000, 32'ha5a50f0f, 32'h13579bdf, 32'hffffdb97},
   '{OP_READ, 5'd5,  5'd17, 2'd0, 2'b01, 32'h00003000, 32'ha5a50f0f, 32'h13579bdf, 32'h80000100},
   '{OP_READ, 5'd17, 5'd5,  2'd2, 2'b00, 32'h00000000, 32'h13579bdf, 32'ha5a50f0f, 32'h00003000},
   '{OP_WRD,  5'd9,  5'd0,  2'd1, 2'b10, 32'h77778888, 32'h0, 32'h0, 32'h0},
   '{OP_READ, 5'd9,  5'd5,  2'd1, 2'b10, 32'h77778888, 32'h77778888, 32'ha5a50f0f, 32'h77778888},
   '{OP_READ, 5'd9,  5'd17, 2'd3, 2'b00, 32'h00000000, 32'h77778888, 32'h13579bdf, 32'hffffcfff}
};

`endif

/* testbench/tb_serial_regfile.sv */
`timescale 1ns/1ns

module tb_serial_regfile;
   import rf_pkg::*;

`include "tb_vectors.svh"

   localparam int CLK_PERIOD = 4;
   localparam int N_FILL = 32;
   localparam int N_RAND = 24;
   localparam int WATCHDOG_CYCLES = (N_VEC + N_FILL + N_RAND) * 40 + 100;

   logic     i_clk;
   logic     i_rst;
   logic     i_trap;
   logic     i_mepc;
   logic     i_mtval;
   logic     i_csr_en;
   csr_sel_e i_csr_addr;
   logic     i_csr;
   logic     i_rd_wen;
   logic [4:0] i_rd_waddr;
   logic     i_rd;
   logic     i_rreq;
   logic [4:0] i_rs1_raddr;
   logic [4:0] i_rs2_raddr;
   logic     o_rgnt;
   logic     o_rs1;
   logic     o_rs2;
   logic     o_csr;
   logic     o_csr_pc;

   // Reference contents, updated after every transaction
   logic [31:0] model_gpr [32];
   logic [31:0] model_csr [4];

   int          seed;
   logic [31:0] rnd;
   logic [31:0] rand_data;
   csr_sel_e    rand_csr;
   logic [31:0] exp_pc;

   serial_regfile u_dut (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_trap      (i_trap),
      .i_mepc      (i_mepc),
      .i_mtval     (i_mtval),
      .o_csr_pc    (o_csr_pc),
      .i_csr_en    (i_csr_en),
      .i_csr_addr  (i_csr_addr),
      .i_csr       (i_csr),
      .o_csr       (o_csr),
      .i_rd_wen    (i_rd_wen),
      .i_rd_waddr  (i_rd_waddr),
      .i_rd        (i_rd),
      .i_rreq      (i_rreq),
      .o_rgnt      (o_rgnt),
      .i_rs1_raddr (i_rs1_raddr),
      .o_rs1       (o_rs1),
      .i_rs2_raddr (i_rs2_raddr),
      .o_rs2       (o_rs2)
   );

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   task automatic check_value(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
      if (act_val !== exp_val) begin
         $display("Error: %s expected %h actual %h", name, exp_val, act_val);
         $display("Simulation failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // One transaction of 37 cycles, entered and left on a falling edge
   task automatic run_op(input logic [1:0] op, input logic [4:0] ra1, input logic [4:0] ra2,
                         input csr_sel_e csr, input logic [1:0] flags, input logic [31:0] data,
                         input logic [31:0] exp_rs1, input logic [31:0] exp_rs2,
                         input logic [31:0] exp_csr_word, input string name);
      logic [31:0] got_rs1;
      logic [31:0] got_rs2;
      logic [31:0] got_csr;
      logic [31:0] got_pc;
      logic [31:0] wbits;
      logic [31:0] mbits;
      int          gnt_cyc;
      int          nbits;
      logic        rd_op;
      logic        wr_csr;
      logic        wr_trap;
      rd_op   = (op == OP_READ);
      wr_csr  = (op == OP_WCSR) || flags[1];
      wr_trap = (op == OP_TRAP) || flags[0];
      gnt_cyc = -1;
      nbits   = 0;
      got_rs1 = '0;
      got_rs2 = '0;
      got_csr = '0;
      got_pc  = '0;
      i_rd_wen    = (op == OP_WRD);
      i_csr_en    = wr_csr;
      i_trap      = wr_trap;
      i_csr_addr  = csr;
      i_rd_waddr  = ra1;
      i_rs1_raddr = ra1;
      i_rs2_raddr = ra2;
      for (int c = 0; c < 36; c++) begin
         // mtval stream carries the inverted word
         wbits   = data >> c;
         mbits   = (~data) >> c;
         i_rreq  = rd_op && (c == 0);
         i_rd    = wbits[0];
         i_csr   = wbits[0];
         i_mepc  = wbits[0];
         i_mtval = mbits[0];
         if (rd_op && gnt_cyc < 0 && o_rgnt) begin
            gnt_cyc = c;
         end else begin
            check_value({name, " grant"}, 32'd0, {31'd0, o_rgnt});
         end
         if (rd_op && gnt_cyc < 0 && c >= 8) begin
            $display("Read request in %s got no grant within 8 cycles", name);
            $display("Simulation failed");
            $fatal(1, "missing grant");
         end
         if (gnt_cyc >= 0 && nbits < 32) begin
            got_rs1[nbits] = o_rs1;
            got_rs2[nbits] = o_rs2;
            got_csr[nbits] = o_csr;
            got_pc[nbits]  = o_csr_pc;
            nbits = nbits + 1;
         end
         @(negedge i_clk);
      end
      i_rd_wen = 1'b0;
      i_csr_en = 1'b0;
      i_trap   = 1'b0;
      @(negedge i_clk);
      if (rd_op) begin
         check_value({name, " grant latency"}, 32'd4, gnt_cyc);
         check_value({name, " rs1"}, exp_rs1, got_rs1);
         check_value({name, " rs2"}, exp_rs2, got_rs2);
         check_value({name, " csr_pc"}, exp_csr_word, got_pc);
         check_value({name, " csr"}, flags[1] ? exp_csr_word : 32'd0, got_csr);
      end
      // Same-nibble order as the write rounds, so the CSR source wins over a trap
      if (wr_trap) begin
         model_csr[CSR_MEPC]  = data;
         model_csr[CSR_MTVAL] = ~data;
      end
      if (wr_csr) begin
         model_csr[csr] = data;
      end
      if (op == OP_WRD) begin
         model_gpr[ra1] = data;
      end
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      seed        = 32'ha67da8a0;
      i_rst       = 1'b1;
      i_trap      = 1'b0;
      i_mepc      = 1'b0;
      i_mtval     = 1'b0;
      i_csr_en    = 1'b0;
      i_csr_addr  = CSR_MSCRATCH;
      i_csr       = 1'b0;
      i_rd_wen    = 1'b0;
      i_rd_waddr  = 5'd0;
      i_rd        = 1'b0;
      i_rreq      = 1'b0;
      i_rs1_raddr = 5'd0;
      i_rs2_raddr = 5'd0;
      repeat (10) @(negedge i_clk);
      i_rst = 1'b0;
      check_value("grant after reset", 32'd0, {31'd0, o_rgnt});

      for (int i = 0; i < N_VEC; i++) begin
         run_op(VEC_TBL[i].op, VEC_TBL[i].ra1, VEC_TBL[i].ra2, csr_sel_e'(VEC_TBL[i].csr),
                VEC_TBL[i].flags, VEC_TBL[i].data, VEC_TBL[i].exp_rs1, VEC_TBL[i].exp_rs2,
                VEC_TBL[i].exp_pc, $sformatf("vector %0d", i));
      end

      // Every register and CSR gets a known value before random reads
      for (int r = 0; r < N_FILL; r++) begin
         rand_data = $random(seed);
         run_op(OP_WRD, 5'(r), 5'd0, csr_sel_e'(r[1:0]), 2'b10, rand_data,
                32'd0, 32'd0, 32'd0, $sformatf("fill %0d", r));
      end

      for (int i = 0; i < N_RAND; i++) begin
         rnd       = $random(seed);
         rand_data = $random(seed);
         rand_csr  = csr_sel_e'(rnd[13:12]);
         exp_pc    = rnd[14] ? model_csr[CSR_MTVEC] : model_csr[rand_csr];
         run_op(rnd[1:0], rnd[6:2], rnd[11:7], rand_csr, rnd[15:14], rand_data,
                model_gpr[rnd[6:2]], model_gpr[rnd[11:7]], exp_pc,
                $sformatf("random %0d", i));
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* verilog/serial_regfile.sv */
`timescale 1ns/1ns

module serial_regfile #(
   parameter int RAM_DEPTH = 512
) (
   input  logic             i_clk,
   input  logic             i_rst,
   // Trap
   input  logic             i_trap,
   input  logic             i_mepc,
   input  logic             i_mtval,
   output logic             o_csr_pc,
   // CSR
   input  logic             i_csr_en,
   input  rf_pkg::csr_sel_e i_csr_addr,
   input  logic             i_csr,
   output logic             o_csr,
   // rd write
   input  logic             i_rd_wen,
   input  logic [4:0]       i_rd_waddr,
   input  logic             i_rd,
   // Read request and operands
   input  logic             i_rreq,
   output logic             o_rgnt,
   input  logic [4:0]       i_rs1_raddr,
   output logic             o_rs1,
   input  logic [4:0]       i_rs2_raddr,
   output logic             o_rs2
);
   import rf_pkg::*;

   logic                      wen;
   logic [RF_ADDR_BITS-1:0]   waddr;
   logic [RF_NIBBLE_BITS-1:0] wdata;
   logic [RF_ADDR_BITS-1:0]   raddr;
   logic [RF_NIBBLE_BITS-1:0] rdata;

   rf_write_gather u_gather (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_trap     (i_trap),
      .i_mepc     (i_mepc),
      .i_mtval    (i_mtval),
      .i_csr_en   (i_csr_en),
      .i_csr_addr (i_csr_addr),
      .i_csr      (i_csr),
      .i_rd_wen   (i_rd_wen),
      .i_rd_waddr (i_rd_waddr),
      .i_rd       (i_rd),
      .o_wen      (wen),
      .o_waddr    (waddr),
      .o_wdata    (wdata)
   );

   rf_read_scatter u_scatter (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_rreq      (i_rreq),
      .i_trap      (i_trap),
      .i_csr_addr  (i_csr_addr),
      .i_csr_en    (i_csr_en),
      .i_rs1_raddr (i_rs1_raddr),
      .i_rs2_raddr (i_rs2_raddr),
      .o_raddr     (raddr),
      .i_rdata     (rdata),
      .o_rgnt      (o_rgnt),
      .o_rs1       (o_rs1),
      .o_rs2       (o_rs2),
      .o_csr       (o_csr),
      .o_csr_pc    (o_csr_pc)
   );

   rf_nibble_ram #(
      .RAM_DEPTH (RAM_DEPTH)
   ) u_ram (
      .i_clk   (i_clk),
      .i_wen   (wen),
      .i_waddr (waddr),
      .i_wdata (wdata),
      .i_raddr (raddr),
      .o_rdata (rdata)
   );

endmodule

/* verilog/rf_read_scatter.sv */
`timescale 1ns/1ns

module rf_read_scatter (
   input  logic                              i_clk,
   input  logic                              i_rst,
   input  logic                              i_rreq,
   input  logic                              i_trap,
   input  rf_pkg::csr_sel_e                  i_csr_addr,
   input  logic                              i_csr_en,
   input  logic [4:0]                        i_rs1_raddr,
   input  logic [4:0]                        i_rs2_raddr,
   output logic [rf_pkg::RF_ADDR_BITS-1:0]   o_raddr,
   input  logic [rf_pkg::RF_NIBBLE_BITS-1:0] i_rdata,
   output logic                              o_rgnt,
   output logic                              o_rs1,
   output logic                              o_rs2,
   output logic                              o_csr,
   output logic                              o_csr_pc
);
   import rf_pkg::*;

   // Phases rs1, rs2, CSR and spare
   logic [3:0] slot;
   logic [3:0] slot_cur;
   logic [2:0] nib;
   logic [2:0] nib_cur;
   logic [2:0] rreq_d;
   csr_sel_e   rcsr;

   // Staggered so all three streams emit bit 0 in the same cycle
   logic [RF_NIBBLE_BITS+1:0] sh_rs1;
   logic [RF_NIBBLE_BITS:0]   sh_rs2;
   logic [RF_NIBBLE_BITS-1:0] sh_csr;

   // rs1 nibble 0 is addressed in the request cycle itself
   assign slot_cur = i_rreq ? 4'b0001 : slot;
   assign nib_cur  = i_rreq ? 3'd0 : nib;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         slot <= 4'b0000;
         nib  <= 3'd0;
      end else if (i_rreq) begin
         slot <= 4'b0010;
         nib  <= 3'd0;
      end else begin
         slot <= {slot[2:0], slot[3]};
         if (slot[3]) begin
            nib <= nib + 3'd1;
         end
      end
   end

   // Grant four cycles after the request
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rreq_d <= 3'd0;
         o_rgnt <= 1'b0;
      end else begin
         rreq_d <= {rreq_d[1:0], i_rreq};
         o_rgnt <= rreq_d[2];
      end
   end

   assign rcsr = i_trap ? CSR_MTVEC : i_csr_addr;

   always_comb begin
      if (slot_cur[0]) begin
         o_raddr = {1'b0, i_rs1_raddr, nib_cur};
      end else if (slot_cur[1]) begin
         o_raddr = {1'b0, i_rs2_raddr, nib_cur};
      end else begin
         o_raddr = RF_CSR_BASE + {4'd0, rcsr, nib_cur};
      end
   end

   // RAM data lags the address by one phase, so slot[k+1] marks stream k data
   always_ff @(posedge i_clk) begin
      sh_rs1 <= sh_rs1 >> 1;
      sh_rs2 <= sh_rs2 >> 1;
      sh_csr <= sh_csr >> 1;
      if (slot[1]) begin
         sh_rs1[RF_NIBBLE_BITS+1:2] <= i_rdata;
      end
      if (slot[2]) begin
         sh_rs2[RF_NIBBLE_BITS:1] <= i_rdata;
      end
      if (slot[3]) begin
         sh_csr <= i_rdata;
      end
   end

   assign o_rs1    = sh_rs1[0];
   assign o_rs2    = sh_rs2[0];
   assign o_csr_pc = sh_csr[0];
   assign o_csr    = sh_csr[0] & i_csr_en;

   // Grant cycle lines up with the first rs1 phase of nibble 1
   a_rgnt_aligned: assert property (
      @(posedge i_clk) disable iff (i_rst)
      (o_rgnt && (rreq_d == 3'b000)) |-> (slot == 4'b0001) && (nib == 3'd1)
   ) else $error("grant not aligned with nibble 0 of the read streams");

endmodule

/* verilog/rf_write_gather.sv */
`timescale 1ns/1ns

module rf_write_gather (
   input  logic                              i_clk,
   input  logic                              i_rst,
   input  logic                              i_trap,
   input  logic                              i_mepc,
   input  logic                              i_mtval,
   input  logic                              i_csr_en,
   input  rf_pkg::csr_sel_e                  i_csr_addr,
   input  logic                              i_csr,
   input  logic                              i_rd_wen,
   input  logic [4:0]                        i_rd_waddr,
   input  logic                              i_rd,
   output logic                              o_wen,
   output logic [rf_pkg::RF_ADDR_BITS-1:0]   o_waddr,
   output logic [rf_pkg::RF_NIBBLE_BITS-1:0] o_wdata
);
   import rf_pkg::*;

   typedef enum logic [1:0] {
      G_IDLE,
      G_FILL,
      G_WRITE
   } gather_state_e;

   gather_state_e state;
   logic [3:0]    slot;
   logic [2:0]    nib;
   logic [3:0]    src_en;
   logic [4:0]    rd_addr_r;
   csr_sel_e      csr_addr_r;
   csr_sel_e      wcsr;
   logic          start_req;
   logic          start;

   // One extra stage per slot so each source has its nibble in [3:0] on its phase
   logic [RF_NIBBLE_BITS:0]   sh_mepc;
   logic [RF_NIBBLE_BITS+1:0] sh_mtval;
   logic [RF_NIBBLE_BITS+2:0] sh_csr;
   logic [RF_NIBBLE_BITS+3:0] sh_rd;

   assign start_req = i_rd_wen | i_csr_en | i_trap;
   assign start     = (state == G_IDLE) && start_req;

   // Streams arrive LSB first, shift right
   always_ff @(posedge i_clk) begin
      sh_mepc  <= {i_mepc, sh_mepc[RF_NIBBLE_BITS:1]};
      sh_mtval <= {i_mtval, sh_mtval[RF_NIBBLE_BITS+1:1]};
      sh_csr   <= {i_csr, sh_csr[RF_NIBBLE_BITS+2:1]};
      sh_rd    <= {i_rd, sh_rd[RF_NIBBLE_BITS+3:1]};
   end

   // Source set and targets captured at start
   always_ff @(posedge i_clk) begin
      if (start) begin
         src_en[SRC_MEPC]  <= i_trap;
         src_en[SRC_MTVAL] <= i_trap;
         src_en[SRC_CSR]   <= i_csr_en;
         src_en[SRC_RD]    <= i_rd_wen;
         rd_addr_r         <= i_rd_waddr;
         csr_addr_r        <= i_csr_addr;
      end
   end

   // One fill round while the shifters load, then 8 write rounds
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state <= G_IDLE;
         slot  <= 4'b0000;
         nib   <= 3'd0;
      end else begin
         case (state)
            G_IDLE: begin
               if (start) begin
                  state <= G_FILL;
                  slot  <= 4'b0001;
               end
            end
            G_FILL: begin
               slot <= {slot[2:0], slot[3]};
               if (slot[3]) begin
                  state <= G_WRITE;
                  nib   <= 3'd0;
               end
            end
            G_WRITE: begin
               slot <= {slot[2:0], slot[3]};
               if (slot[3]) begin
                  nib <= nib + 3'd1;
                  // Last nibble written
                  if (nib == 3'(RF_NIB_PER_WORD - 1)) begin
                     state <= G_IDLE;
                     slot  <= 4'b0000;
                  end
               end
            end
            default: begin
               state <= G_IDLE;
               slot  <= 4'b0000;
            end
         endcase
      end
   end

   always_comb begin
      if (slot[SRC_MEPC]) begin
         o_wdata = sh_mepc[RF_NIBBLE_BITS-1:0];
      end else if (slot[SRC_MTVAL]) begin
         o_wdata = sh_mtval[RF_NIBBLE_BITS-1:0];
      end else if (slot[SRC_CSR]) begin
         o_wdata = sh_csr[RF_NIBBLE_BITS-1:0];
      end else begin
         o_wdata = sh_rd[RF_NIBBLE_BITS-1:0];
      end
   end

   // Trap slots have fixed CSR targets
   always_comb begin
      if (slot[SRC_MEPC]) begin
         wcsr = CSR_MEPC;
      end else if (slot[SRC_MTVAL]) begin
         wcsr = CSR_MTVAL;
      end else begin
         wcsr = csr_addr_r;
      end
   end

   assign o_waddr = slot[SRC_RD] ? {1'b0, rd_addr_r, nib}
                                 : RF_CSR_BASE + {4'd0, wcsr, nib};

   assign o_wen = (state == G_WRITE) && (|(slot & src_en));

   a_start_idle: assert property (
      @(posedge i_clk) disable iff (i_rst)
      $rose(start_req) |-> (state == G_IDLE)
   ) else $error("write start requested while gather unit is busy");

endmodule

/* verilog/rf_nibble_ram.sv */
`timescale 1ns/1ns

module rf_nibble_ram #(
   parameter int RAM_DEPTH = 512
) (
   input  logic                              i_clk,
   input  logic                              i_wen,
   input  logic [rf_pkg::RF_ADDR_BITS-1:0]   i_waddr,
   input  logic [rf_pkg::RF_NIBBLE_BITS-1:0] i_wdata,
   input  logic [rf_pkg::RF_ADDR_BITS-1:0]   i_raddr,
   output logic [rf_pkg::RF_NIBBLE_BITS-1:0] o_rdata
);
   import rf_pkg::*;

   logic [RF_NIBBLE_BITS-1:0] mem [RAM_DEPTH];

   // Read during write to the same location returns the old nibble
   always_ff @(posedge i_clk) begin
      if (i_wen) begin
         mem[i_waddr] <= i_wdata;
      end
      o_rdata <= mem[i_raddr];
   end

   a_waddr_range: assert property (
      @(posedge i_clk)
      i_wen |-> (int'(i_waddr) < RAM_DEPTH)
   ) else $error("write address %0d outside RAM depth %0d", i_waddr, RAM_DEPTH);

endmodule

/* verilog/rf_pkg.sv */
package rf_pkg;

   // Serial word and RAM nibble sizes
   localparam int RF_WORD_BITS   = 32;
   localparam int RF_NIBBLE_BITS = 4;
   localparam int RF_ADDR_BITS   = 9;

   localparam int RF_NIB_PER_WORD = RF_WORD_BITS / RF_NIBBLE_BITS;

   // RAM layout
   // GPR r nibble n at r*8+n
   // CSR c nibble n at RF_CSR_BASE + c*8+n
   localparam logic [RF_ADDR_BITS-1:0] RF_CSR_BASE = 9'd256;

   // Machine CSR slots
   typedef enum logic [1:0] {
      CSR_MSCRATCH = 2'd0,
      CSR_MTVEC    = 2'd1,
      CSR_MEPC     = 2'd2,
      CSR_MTVAL    = 2'd3
   } csr_sel_e;

   // Write sources, also the phase order of one write round
   typedef enum logic [1:0] {
      SRC_MEPC  = 2'd0,
      SRC_MTVAL = 2'd1,
      SRC_CSR   = 2'd2,
      SRC_RD    = 2'd3
   } wr_src_e;

endpackage
